// File: Makefile
# Verilator build and run of the scroll layer testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_scroll -f filelist.f -o sim_scroll
	./obj_dir/sim_scroll > $(LOG); cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: common/scroll_pkg.sv
// **********************************************************
// layer select encoding, memory words and tile sizes
// **********************************************************
package scroll_pkg;

    // one-hot layer select
    typedef logic [2:0] layer_t;

    localparam layer_t layer1 = 3'b001;
    localparam layer_t layer2 = 3'b010;
    localparam layer_t layer3 = 3'b100;

    typedef logic [15:0] vram_word_t;
    typedef logic [16:0] vram_addr_t;  // word address

    // eight 4-bit pixels, pixel 0 in the top nibble
    typedef logic [31:0] rom_word_t;
    typedef logic [19:0] rom_addr_t;

    localparam int tile_size1 = 8;
    localparam int tile_size2 = 16;
    localparam int tile_size3 = 32;

endpackage

// File: common/video_pkg.sv
// **********************************************************
// screen geometry and layer pixel format
// **********************************************************
package video_pkg;

    localparam int hcount_w  = 9;     // h and v counters
    localparam int buf_depth = 1024;  // two line halves of 512 pixels

    typedef logic [hcount_w-1:0] hcount_t;

    // upper 7 bits palette, lower 4 bits colour
    typedef logic [10:0] pixel_t;

    // top bit selects the buffer half, the rest is pixel x
    typedef logic [hcount_w:0] buf_addr_t;

    localparam pixel_t blank_pixel = 11'h1ff;  // outside active area

endpackage

// File: filelist.f
+incdir+verif
common/video_pkg.sv
common/scroll_pkg.sv
src/dual_port_ram.sv
scroll/layer_seq.sv
scroll/tile_fetch.sv
scroll/line_store.sv
src/scroll_top.sv
verif/tb_scroll.sv

// File: scroll/layer_seq.sv
// **********************************************************
// per-line layer sequencer and line buffer half control
// **********************************************************
`timescale 1ns/1ns

module layer_seq (
    input  logic                   rst,
    input  logic                   clk,
    input  logic                   start,
    input  scroll_pkg::vram_word_t vram1_base,
    input  scroll_pkg::vram_word_t vram2_base,
    input  scroll_pkg::vram_word_t vram3_base,
    input  scroll_pkg::vram_word_t hpos1,
    input  scroll_pkg::vram_word_t vpos1,
    input  scroll_pkg::vram_word_t hpos2,
    input  scroll_pkg::vram_word_t vpos2,
    input  scroll_pkg::vram_word_t hpos3,
    input  scroll_pkg::vram_word_t vpos3,
    output scroll_pkg::layer_t     layer,
    output scroll_pkg::vram_word_t hpos,
    output scroll_pkg::vram_word_t vpos,
    output scroll_pkg::vram_word_t vram_base,
    output logic                   fetch_start,
    output logic                   fetch_abort,
    input  logic                   fetch_done,
    output logic                   wr_half,
    output logic                   rd_half,
    output logic                   done
);

    logic               last_start;
    logic               req;   // one pending line request
    logic               busy;
    logic               launch;
    logic               load;
    scroll_pkg::layer_t next_layer;

    assign fetch_abort = start & ~last_start;
    assign launch      = req & ~busy;

    always_comb begin
        load       = 1'b0;
        next_layer = layer;
        if (launch) begin
            load       = 1'b1;
            next_layer = scroll_pkg::layer1;
        end else if (busy && fetch_done && layer != scroll_pkg::layer3) begin
            load       = 1'b1;
            next_layer = scroll_pkg::layer_t'({layer[1:0], 1'b0});  // one-hot step
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_start  <= 1'b0;
            req         <= 1'b0;
            busy        <= 1'b0;
            layer       <= scroll_pkg::layer1;
            fetch_start <= 1'b0;
            done        <= 1'b0;
            rd_half     <= 1'b0;
            wr_half     <= 1'b1;
        end else begin
            last_start  <= start;
            fetch_start <= load;
            done        <= 1'b0;
            if (load) begin
                layer <= next_layer;
            end
            if (launch) begin
                wr_half <= ~wr_half;
                req     <= 1'b0;
                busy    <= 1'b1;
            end else if (busy && fetch_done && layer == scroll_pkg::layer3) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            // edge wins over the launch clearing req
            if (fetch_abort) begin
                req     <= 1'b1;
                rd_half <= ~rd_half;
            end
        end
    end

    // layer registers held for the fetcher
    always_ff @(posedge clk) begin
        if (load) begin
            case (next_layer)
                scroll_pkg::layer2: begin
                    hpos      <= hpos2;
                    vpos      <= vpos2;
                    vram_base <= vram2_base;
                end
                scroll_pkg::layer3: begin
                    hpos      <= hpos3;
                    vpos      <= vpos3;
                    vram_base <= vram3_base;
                end
                default: begin
                    hpos      <= hpos1;
                    vpos      <= vpos1;
                    vram_base <= vram1_base;
                end
            endcase
        end
    end

endmodule

// File: scroll/line_store.sv
// **********************************************************
// double-buffered line memories and blanked pixel outputs
// **********************************************************
`timescale 1ns/1ns

module line_store #(
    parameter int active_start = 64,
    parameter int active_end   = 448
) (
    input  logic                 rst,
    input  logic                 clk,
    input  logic                 pxl_cen,
    input  video_pkg::hcount_t   hdump,
    input  scroll_pkg::layer_t   layer,
    input  logic                 buf_wr,
    input  video_pkg::buf_addr_t buf_addr,
    input  video_pkg::pixel_t    buf_data,
    input  logic                 rd_half,
    output video_pkg::pixel_t    scr1_pxl,
    output video_pkg::pixel_t    scr2_pxl,
    output video_pkg::pixel_t    scr3_pxl
);

    video_pkg::pixel_t    pre_pxl [3];
    video_pkg::buf_addr_t rd_addr;
    logic                 active;

    assign rd_addr = {rd_half, hdump};
    assign active  = hdump >= 9'(active_start) && hdump < 9'(active_end);

    // one memory per layer, write steered by the one-hot layer
    for (genvar i = 0; i < 3; i++) begin : g_line
        dual_port_ram i_ram (
            .clk     (clk),
            .wr_addr (buf_addr),
            .wr_data (buf_data),
            .wr_en   (buf_wr & layer[i]),
            .rd_addr (rd_addr),
            .rd_data (pre_pxl[i])
        );
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scr1_pxl <= video_pkg::blank_pixel;
            scr2_pxl <= video_pkg::blank_pixel;
            scr3_pxl <= video_pkg::blank_pixel;
        end else if (pxl_cen) begin
            scr1_pxl <= active ? pre_pxl[0] : video_pkg::blank_pixel;
            scr2_pxl <= active ? pre_pxl[1] : video_pkg::blank_pixel;
            scr3_pxl <= active ? pre_pxl[2] : video_pkg::blank_pixel;
        end
    end

endmodule

// File: scroll/tile_fetch.sv
// **********************************************************
// VRAM and ROM fetch engine, writes one layer line of pixels
// **********************************************************
`timescale 1ns/1ns

module tile_fetch #(
    parameter int active_start = 64,
    parameter int active_end   = 448
) (
    input  logic                   rst,
    input  logic                   clk,
    input  video_pkg::hcount_t     vrender,
    input  scroll_pkg::layer_t     layer,
    input  scroll_pkg::vram_word_t hpos,
    input  scroll_pkg::vram_word_t vpos,
    input  scroll_pkg::vram_word_t vram_base,
    input  logic                   wr_half,
    input  logic                   fetch_start,
    input  logic                   fetch_abort,
    output logic                   fetch_done,
    output scroll_pkg::vram_addr_t vram_addr,
    input  scroll_pkg::vram_word_t vram_data,
    input  logic                   vram_ok,
    output logic                   vram_cs,
    output scroll_pkg::rom_addr_t  rom_addr,
    input  scroll_pkg::rom_word_t  rom_data,
    input  logic                   rom_ok,
    output logic                   rom_cs,
    output logic                   buf_wr,
    output video_pkg::buf_addr_t   buf_addr,
    output video_pkg::pixel_t      buf_data
);

    typedef enum logic [2:0] {st_idle, st_code, st_attr, st_rom, st_pixel} state_t;

    state_t                 st;
    logic [5:0]             col;       // tile column in the map
    logic [1:0]             word_cnt;
    logic [2:0]             pix_cnt;
    logic [10:0]            sx;        // screen x of the next pixel
    scroll_pkg::vram_word_t code;
    logic [6:0]             pal;
    logic                   hflip;
    scroll_pkg::rom_word_t  pix_sr;

    scroll_pkg::vram_word_t ly;
    logic [5:0]             size;
    logic [5:0]             map_row;
    logic [5:0]             first_col;
    logic [4:0]             tile_row;
    logic [4:0]             hoff;
    logic [1:0]             last_word;
    logic [1:0]             word_idx;
    scroll_pkg::rom_addr_t  rom_next;
    scroll_pkg::vram_addr_t vram_word_addr;
    logic                   in_area;
    logic                   last_pix;

    always_comb begin
        ly = vpos + scroll_pkg::vram_word_t'(vrender);
        case (layer)
            scroll_pkg::layer2: begin
                size      = 6'(scroll_pkg::tile_size2);
                map_row   = ly[9:4];
                first_col = hpos[9:4];
            end
            scroll_pkg::layer3: begin
                size      = 6'(scroll_pkg::tile_size3);
                map_row   = ly[10:5];
                first_col = hpos[10:5];
            end
            default: begin
                size      = 6'(scroll_pkg::tile_size1);
                map_row   = ly[8:3];
                first_col = hpos[8:3];
            end
        endcase
        tile_row  = ly[4:0] & 5'(size - 6'd1);
        hoff      = hpos[4:0] & 5'(size - 6'd1);
        last_word = 2'((size >> 3) - 6'd1);
        word_idx  = hflip ? last_word - word_cnt : word_cnt;
        // (code * size + row) * words per row + word, kept to 20 bits
        rom_next  = scroll_pkg::rom_addr_t'((32'(code) * 32'(size) + 32'(tile_row))
                    * 32'(size >> 3) + 32'(word_idx));
    end

    // code at base*64 + index*2, attribute right after it
    assign vram_word_addr = scroll_pkg::vram_addr_t'({vram_base, 6'd0})
                          + scroll_pkg::vram_addr_t'({map_row, col, st == st_attr});
    assign in_area  = sx >= 11'(active_start) && sx < 11'(active_end);
    assign last_pix = pix_cnt == 3'd7;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st         <= st_idle;
            vram_cs    <= 1'b0;
            rom_cs     <= 1'b0;
            buf_wr     <= 1'b0;
            fetch_done <= 1'b0;
            col        <= '0;
            word_cnt   <= '0;
            pix_cnt    <= '0;
            sx         <= '0;
        end else begin
            fetch_done <= 1'b0;
            buf_wr     <= 1'b0;
            if (fetch_abort) begin
                st         <= st_idle;
                vram_cs    <= 1'b0;
                rom_cs     <= 1'b0;
                fetch_done <= st != st_idle || fetch_start;  // let the sequencer move on
            end else begin
                case (st)
                    st_idle: if (fetch_start) begin
                        st  <= st_code;
                        col <= first_col;
                        sx  <= 11'(active_start) - 11'(hoff);  // first tile may start early
                    end
                    st_code: begin
                        vram_cs <= !(vram_cs && vram_ok);
                        if (vram_cs && vram_ok) begin
                            st <= st_attr;
                        end
                    end
                    st_attr: begin
                        vram_cs <= !(vram_cs && vram_ok);
                        if (vram_cs && vram_ok) begin
                            st       <= st_rom;
                            word_cnt <= '0;
                        end
                    end
                    st_rom: begin
                        rom_cs <= !(rom_cs && rom_ok);
                        if (rom_cs && rom_ok) begin
                            st      <= st_pixel;
                            pix_cnt <= '0;
                        end
                    end
                    st_pixel: begin
                        buf_wr  <= in_area;
                        sx      <= sx + 11'd1;
                        pix_cnt <= pix_cnt + 3'd1;
                        if (last_pix) begin
                            if (word_cnt != last_word) begin
                                word_cnt <= word_cnt + 2'd1;
                                st       <= st_rom;
                            end else if (sx + 11'd1 >= 11'(active_end)) begin
                                st         <= st_idle;  // tile covered active_end-1
                                fetch_done <= 1'b1;
                            end else begin
                                col <= col + 6'd1;  // wraps at 64 tiles
                                st  <= st_code;
                            end
                        end
                    end
                    default: st <= st_idle;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        case (st)
            st_code: begin
                vram_addr <= vram_word_addr;
                if (vram_cs && vram_ok) begin
                    code <= vram_data;
                end
            end
            st_attr: begin
                vram_addr <= vram_word_addr;
                if (vram_cs && vram_ok) begin
                    pal   <= vram_data[6:0];
                    hflip <= vram_data[13];
                end
            end
            st_rom: begin
                rom_addr <= rom_next;
                if (rom_cs && rom_ok) begin
                    pix_sr <= rom_data;
                end
            end
            st_pixel: begin
                buf_addr <= {wr_half, sx[8:0]};
                buf_data <= {pal, hflip ? pix_sr[3:0] : pix_sr[31:28]};
                pix_sr   <= hflip ? pix_sr >> 4 : pix_sr << 4;  // reversed order on hflip
            end
            default: ;
        endcase
    end

endmodule

// File: src/dual_port_ram.sv
// **********************************************************
// line memory, one write port and a registered read port
// **********************************************************
`timescale 1ns/1ns

module dual_port_ram (
    input  logic                 clk,
    input  video_pkg::buf_addr_t wr_addr,
    input  video_pkg::pixel_t    wr_data,
    input  logic                 wr_en,
    input  video_pkg::buf_addr_t rd_addr,
    output video_pkg::pixel_t    rd_data
);

    video_pkg::pixel_t mem [video_pkg::buf_depth];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];  // one clock of read latency
    end

endmodule

// File: src/scroll_top.sv
// **********************************************************
// tile scroll layer generator, top level
// **********************************************************
`timescale 1ns/1ns

module scroll_top #(
    parameter int active_start = 64,
    parameter int active_end   = 448
) (
    input  logic                   rst,
    input  logic                   clk,
    input  logic                   pxl_cen,
    input  logic                   start,
    input  video_pkg::hcount_t     vrender,   // one line ahead of display
    input  video_pkg::hcount_t     hdump,
    input  scroll_pkg::vram_word_t vram1_base,
    input  scroll_pkg::vram_word_t vram2_base,
    input  scroll_pkg::vram_word_t vram3_base,
    input  scroll_pkg::vram_word_t hpos1,
    input  scroll_pkg::vram_word_t vpos1,
    input  scroll_pkg::vram_word_t hpos2,
    input  scroll_pkg::vram_word_t vpos2,
    input  scroll_pkg::vram_word_t hpos3,
    input  scroll_pkg::vram_word_t vpos3,
    output scroll_pkg::vram_addr_t vram_addr,
    output logic                   vram_cs,
    input  scroll_pkg::vram_word_t vram_data,
    input  logic                   vram_ok,
    output scroll_pkg::rom_addr_t  rom_addr,
    output logic                   rom_cs,
    input  scroll_pkg::rom_word_t  rom_data,
    input  logic                   rom_ok,
    output video_pkg::pixel_t      scr1_pxl,
    output video_pkg::pixel_t      scr2_pxl,
    output video_pkg::pixel_t      scr3_pxl,
    output logic                   done
);

    scroll_pkg::layer_t     layer;
    scroll_pkg::vram_word_t hpos;
    scroll_pkg::vram_word_t vpos;
    scroll_pkg::vram_word_t vram_base;
    logic                   fetch_start;
    logic                   fetch_abort;
    logic                   fetch_done;
    logic                   wr_half;
    logic                   rd_half;
    logic                   buf_wr;
    video_pkg::buf_addr_t   buf_addr;
    video_pkg::pixel_t      buf_data;

    layer_seq i_layer_seq (
        .rst         (rst),
        .clk         (clk),
        .start       (start),
        .vram1_base  (vram1_base),
        .vram2_base  (vram2_base),
        .vram3_base  (vram3_base),
        .hpos1       (hpos1),
        .vpos1       (vpos1),
        .hpos2       (hpos2),
        .vpos2       (vpos2),
        .hpos3       (hpos3),
        .vpos3       (vpos3),
        .layer       (layer),
        .hpos        (hpos),
        .vpos        (vpos),
        .vram_base   (vram_base),
        .fetch_start (fetch_start),
        .fetch_abort (fetch_abort),
        .fetch_done  (fetch_done),
        .wr_half     (wr_half),
        .rd_half     (rd_half),
        .done        (done)
    );

    tile_fetch #(
        .active_start (active_start),
        .active_end   (active_end)
    ) i_tile_fetch (
        .rst         (rst),
        .clk         (clk),
        .vrender     (vrender),
        .layer       (layer),
        .hpos        (hpos),
        .vpos        (vpos),
        .vram_base   (vram_base),
        .wr_half     (wr_half),
        .fetch_start (fetch_start),
        .fetch_abort (fetch_abort),
        .fetch_done  (fetch_done),
        .vram_addr   (vram_addr),
        .vram_data   (vram_data),
        .vram_ok     (vram_ok),
        .vram_cs     (vram_cs),
        .rom_addr    (rom_addr),
        .rom_data    (rom_data),
        .rom_ok      (rom_ok),
        .rom_cs      (rom_cs),
        .buf_wr      (buf_wr),
        .buf_addr    (buf_addr),
        .buf_data    (buf_data)
    );

    line_store #(
        .active_start (active_start),
        .active_end   (active_end)
    ) i_line_store (
        .rst      (rst),
        .clk      (clk),
        .pxl_cen  (pxl_cen),
        .hdump    (hdump),
        .layer    (layer),
        .buf_wr   (buf_wr),
        .buf_addr (buf_addr),
        .buf_data (buf_data),
        .rd_half  (rd_half),
        .scr1_pxl (scr1_pxl),
        .scr2_pxl (scr2_pxl),
        .scr3_pxl (scr3_pxl)
    );

endmodule

// File: verif/scroll_model.svh
// **********************************************************
// VRAM and ROM content functions, reference pixel model
// **********************************************************
`ifndef scroll_model_svh
`define scroll_model_svh

// tile codes and attributes, hashed from the whole word address
function automatic scroll_pkg::vram_word_t vram_word(input scroll_pkg::vram_addr_t addr);
    logic [31:0] h;
    h = 32'(addr) * 32'h9e3779b1;
    h = h ^ (h >> 16);  // high product bits fold back down
    return h[15:0];
endfunction

// eight pixels per word, pixel 0 in the top nibble
function automatic scroll_pkg::rom_word_t rom_word(input scroll_pkg::rom_addr_t addr);
    logic [31:0] h;
    h = 32'(addr) * 32'h85ebca6b;
    h = h ^ (h >> 13);
    h = h * 32'hc2b2ae35;
    return h ^ (h >> 16);
endfunction

// expected pixel of one layer at screen x on a rendered line
function automatic video_pkg::pixel_t model_pixel(input int size, input int x, input int line,
                                                  input int hpos, input int vpos, input int base);
    int                     px;
    int                     py;
    int                     off;
    int                     r;
    scroll_pkg::vram_addr_t code_addr;
    scroll_pkg::vram_word_t code;
    scroll_pkg::vram_word_t attr;
    scroll_pkg::rom_addr_t  pix_addr;
    scroll_pkg::rom_word_t  pix_word;
    px        = x + hpos - active_start;  // layer position
    py        = line + vpos;
    off       = px % size;
    code_addr = scroll_pkg::vram_addr_t'(base * 64
              + ((py / size % 64) * 64 + px / size % 64) * 2);
    code      = vram_word(code_addr);
    attr      = vram_word(code_addr + 17'd1);
    r         = attr[13] ? size - 1 - off : off;  // hflip mirrors the tile row
    pix_addr  = scroll_pkg::rom_addr_t'((int'(code) * size + py % size) * (size / 8) + r / 8);
    pix_word  = rom_word(pix_addr);
    return {attr[6:0], pix_word[31 - 4 * (r % 8) -: 4]};
endfunction

`endif

// File: verif/tb_scroll.sv
// **********************************************************
// testbench for the tile scroll layer generator
// **********************************************************
`timescale 1ns/1ns

module tb_scroll;

    localparam int          active_start   = 64;
    localparam int          active_end     = 448;
    localparam int          n_lines        = 13;  // renders over the whole run
    localparam int          timeout_cycles = 5000 * n_lines;
    localparam logic [31:0] seed           = 32'h51308a46;

    logic                   clk;
    logic                   rst;
    logic                   pxl_cen;
    logic                   start;
    video_pkg::hcount_t     vrender;
    video_pkg::hcount_t     hdump;
    scroll_pkg::vram_word_t reg_base [3];
    scroll_pkg::vram_word_t reg_hpos [3];
    scroll_pkg::vram_word_t reg_vpos [3];
    scroll_pkg::vram_addr_t vram_addr;
    logic                   vram_cs;
    scroll_pkg::vram_word_t vram_data;
    logic                   vram_ok;
    scroll_pkg::rom_addr_t  rom_addr;
    logic                   rom_cs;
    scroll_pkg::rom_word_t  rom_data;
    logic                   rom_ok;
    video_pkg::pixel_t      scr1_pxl;
    video_pkg::pixel_t      scr2_pxl;
    video_pkg::pixel_t      scr3_pxl;
    logic                   done;

    // registers of the line last sent to render, and of the one played back
    scroll_pkg::vram_word_t rend_base [3];
    scroll_pkg::vram_word_t rend_hpos [3];
    scroll_pkg::vram_word_t rend_vpos [3];
    video_pkg::hcount_t     rend_line;
    scroll_pkg::vram_word_t play_base [3];
    scroll_pkg::vram_word_t play_hpos [3];
    scroll_pkg::vram_word_t play_vpos [3];
    video_pkg::hcount_t     play_line;

    logic [31:0] main_seed;
    logic [31:0] vram_seed;
    logic [31:0] rom_seed;
    logic        use_waits;
    int          done_cnt = 0;
    int          launched;
    int          cycle_cnt;
    int          n_checks;
    int          n_errors;
    int          test_errors;
    int          blank_errors;
    int          n_tests;
    int          n_failed;

    `include "scroll_model.svh"

    scroll_top #(
        .active_start (active_start),
        .active_end   (active_end)
    ) i_scroll_top (
        .rst        (rst),
        .clk        (clk),
        .pxl_cen    (pxl_cen),
        .start      (start),
        .vrender    (vrender),
        .hdump      (hdump),
        .vram1_base (reg_base[0]),
        .vram2_base (reg_base[1]),
        .vram3_base (reg_base[2]),
        .hpos1      (reg_hpos[0]),
        .vpos1      (reg_vpos[0]),
        .hpos2      (reg_hpos[1]),
        .vpos2      (reg_vpos[1]),
        .hpos3      (reg_hpos[2]),
        .vpos3      (reg_vpos[2]),
        .vram_addr  (vram_addr),
        .vram_cs    (vram_cs),
        .vram_data  (vram_data),
        .vram_ok    (vram_ok),
        .rom_addr   (rom_addr),
        .rom_cs     (rom_cs),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .scr1_pxl   (scr1_pxl),
        .scr2_pxl   (scr2_pxl),
        .scr3_pxl   (scr3_pxl),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Run stopped after %0d cycles without finishing", cycle_cnt);
        $display("Some tests failed");
        $finish;
    end

    always @(negedge clk) begin
        if (done) begin
            done_cnt++;  // one pulse per rendered line
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] draw_main();
        main_seed = lcg_step(main_seed);
        return main_seed;
    endfunction

    function automatic int layer_size(input int i);
        case (i)
            1: return scroll_pkg::tile_size2;
            2: return scroll_pkg::tile_size3;
            default: return scroll_pkg::tile_size1;
        endcase
    endfunction

    function automatic string pxl_name(input int i);
        case (i)
            1: return "scr2_pxl";
            2: return "scr3_pxl";
            default: return "scr1_pxl";
        endcase
    endfunction

    // VRAM side, answers each held cs after 0 to 3 wait cycles
    initial begin
        int wait_left;
        vram_ok   = 1'b0;
        vram_data = '0;
        wait_left = -1;
        forever begin
            @(posedge clk);
            #2;
            if (vram_ok) begin
                vram_ok = 1'b0;  // single cycle strobe
            end else if (vram_cs) begin
                if (wait_left < 0) begin
                    vram_seed = lcg_step(vram_seed);
                    wait_left = use_waits ? int'(vram_seed[31:30]) : 0;
                end
                if (wait_left == 0) begin
                    vram_ok   = 1'b1;
                    vram_data = vram_word(vram_addr);
                end
                wait_left--;
            end
        end
    end

    // graphics ROM side, same rule
    initial begin
        int wait_left;
        rom_ok    = 1'b0;
        rom_data  = '0;
        wait_left = -1;
        forever begin
            @(posedge clk);
            #2;
            if (rom_ok) begin
                rom_ok = 1'b0;
            end else if (rom_cs) begin
                if (wait_left < 0) begin
                    rom_seed  = lcg_step(rom_seed);
                    wait_left = use_waits ? int'(rom_seed[31:30]) : 0;
                end
                if (wait_left == 0) begin
                    rom_ok   = 1'b1;
                    rom_data = rom_word(rom_addr);
                end
                wait_left--;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp, inout int errs);
        n_checks++;
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            n_errors++;
            errs++;
        end
    endtask

    task automatic check_idle();
        compare_value("scr1_pxl", 32'(scr1_pxl), 32'(video_pkg::blank_pixel), test_errors);
        compare_value("scr2_pxl", 32'(scr2_pxl), 32'(video_pkg::blank_pixel), test_errors);
        compare_value("scr3_pxl", 32'(scr3_pxl), 32'(video_pkg::blank_pixel), test_errors);
        compare_value("vram_cs", 32'(vram_cs), 32'd0, test_errors);
        compare_value("rom_cs", 32'(rom_cs), 32'd0, test_errors);
        compare_value("done", 32'(done), 32'd0, test_errors);
    endtask

    task automatic randomize_regs();
        logic [31:0] r;
        int          i;
        for (i = 0; i < 3; i++) begin
            r           = draw_main();
            reg_base[i] = r[31:16];
            r           = draw_main();
            reg_hpos[i] = r[31:16];
            r           = draw_main();
            reg_vpos[i] = r[31:16];
        end
        r       = draw_main();
        vrender = r[31:23];
    endtask

    // plays back the half in rd_half, one pixel per two clocks
    task automatic sweep_line();
        video_pkg::pixel_t got [3];
        video_pkg::pixel_t exp;
        int                h;
        int                i;
        for (h = 0; h < 512; h++) begin
            hdump   = video_pkg::hcount_t'(h);
            pxl_cen = 1'b0;
            next_cycle();  // read address in
            pxl_cen = 1'b1;
            next_cycle();
            got[0] = scr1_pxl;
            got[1] = scr2_pxl;
            got[2] = scr3_pxl;
            for (i = 0; i < 3; i++) begin
                if (h < active_start || h >= active_end) begin
                    compare_value(pxl_name(i), 32'(got[i]), 32'(video_pkg::blank_pixel),
                                  blank_errors);
                end else begin
                    exp = model_pixel(layer_size(i), h, int'(play_line), int'(play_hpos[i]),
                                      int'(play_vpos[i]), int'(play_base[i]));
                    compare_value(pxl_name(i), 32'(got[i]), 32'(exp), test_errors);
                end
            end
        end
        pxl_cen = 1'b0;
    endtask

    // start edge swaps halves and renders the current registers
    task automatic render_and_play(input logic check);
        play_base = rend_base;
        play_hpos = rend_hpos;
        play_vpos = rend_vpos;
        play_line = rend_line;
        start     = 1'b1;
        launched++;
        next_cycle();
        next_cycle();
        start     = 1'b0;
        next_cycle();
        rend_base = reg_base;
        rend_hpos = reg_hpos;
        rend_vpos = reg_vpos;
        rend_line = vrender;
        if (check) begin
            sweep_line();
        end
        while (done_cnt < launched) begin
            next_cycle();
        end
    endtask

    task automatic end_test(input string name);
        n_tests++;
        if (test_errors == 0) begin
            $display("test %s: pass", name);
        end else begin
            n_failed++;
            $display("test %s: failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        int i;
        rst     = 1'b1;
        pxl_cen = 1'b0;
        start   = 1'b0;
        vrender = '0;
        hdump   = '0;
        for (i = 0; i < 3; i++) begin
            reg_base[i]  = '0;
            reg_hpos[i]  = '0;
            reg_vpos[i]  = '0;
            rend_base[i] = '0;
            rend_hpos[i] = '0;
            rend_vpos[i] = '0;
        end
        rend_line    = '0;
        vram_seed    = lcg_step(seed);
        rom_seed     = lcg_step(vram_seed);
        main_seed    = lcg_step(rom_seed);
        use_waits    = 1'b0;
        launched     = 0;
        n_checks     = 0;
        n_errors     = 0;
        test_errors  = 0;
        blank_errors = 0;
        n_tests      = 0;
        n_failed     = 0;

        repeat (5) @(posedge clk);
        #2;
        check_idle();  // still in reset
        rst = 1'b0;
        next_cycle();
        next_cycle();
        check_idle();
        end_test("reset state");

        reg_base[1] = 16'h0100;  // maps apart in VRAM
        reg_base[2] = 16'h0200;
        vrender     = 9'd40;
        render_and_play(1'b0);
        render_and_play(1'b1);
        end_test("zero scroll");

        use_waits = 1'b1;
        for (i = 0; i < 9; i++) begin
            randomize_regs();
            render_and_play(i > 0);
        end
        end_test("random scroll");

        // new registers while the last random line plays back
        randomize_regs();
        render_and_play(1'b1);
        render_and_play(1'b1);
        end_test("double buffer");

        test_errors = blank_errors;
        end_test("blanking");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 n_tests, n_failed, n_checks, n_errors);
        if (n_failed == 0 && n_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
